//--- Bender.yml
package:
  name: mbus

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/mbus_pkg.sv
      - design/bus_cmd_if.sv
      - design/host_bus_port.sv
      - design/cmd_fifo.sv
      - design/mbus_sequencer.sv
      - design/mbus_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verification/mbus_asserts.sv
      - verification/mbus_tb.sv

//--- design/bus_cmd_if.sv
// Command link with four-phase req/ack
`default_nettype none

interface bus_cmd_if import mbus_pkg::*; ();

	logic      req;
	logic      ack;
	mbus_cmd_t cmd;

	modport producer (
		output req,
		output cmd,
		input  ack
	);

	modport consumer (
		input  req,
		input  cmd,
		output ack
	);

endinterface

`default_nettype wire

//--- design/cmd_fifo.sv
// Command queue
`default_nettype none

`include "mbus_defines.svh"

module cmd_fifo import mbus_pkg::*; (
	input  wire         MCLK,
	input  wire         reset,
	bus_cmd_if.consumer wr,
	bus_cmd_if.producer rd
);

	mbus_cmd_t mem [1 << `FIFO_DEPTH_LOG2];

	// Extra top bit tells full from empty
	logic [`FIFO_DEPTH_LOG2:0] wr_ptr;
	logic [`FIFO_DEPTH_LOG2:0] rd_ptr;
	logic                      empty;
	logic                      full;
	logic                      push;
	logic                      pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[`FIFO_DEPTH_LOG2] != rd_ptr[`FIFO_DEPTH_LOG2]) &&
		(wr_ptr[`FIFO_DEPTH_LOG2-1:0] == rd_ptr[`FIFO_DEPTH_LOG2-1:0]);

	assign push = wr.req && !wr.ack && !full;
	assign pop  = rd.req && rd.ack;

	always_ff @(posedge MCLK) begin
		if (push)
			mem[wr_ptr[`FIFO_DEPTH_LOG2-1:0]] <= wr.cmd;
	end

	// Head entry stays put until its ack
	assign rd.cmd = mem[rd_ptr[`FIFO_DEPTH_LOG2-1:0]];

	//------------------------------
	// Write side
	//------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			wr_ptr <= '0;
			wr.ack <= 1'b0;
		end else if (push) begin
			wr_ptr <= wr_ptr + 1'b1;
			wr.ack <= 1'b1;
		end else if (wr.ack && !wr.req) begin
			wr.ack <= 1'b0;
		end
	end

	//------------------------------
	// Read side
	//------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			rd_ptr <= '0;
			rd.req <= 1'b0;
		end else if (pop) begin
			rd_ptr <= rd_ptr + 1'b1;
			rd.req <= 1'b0;
		end else if (!rd.req && !rd.ack && !empty) begin
			// Previous cycle fully closed
			rd.req <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/host_bus_port.sv
// Host bus port and region decode
`default_nettype none

`include "mbus_defines.svh"

module host_bus_port import mbus_pkg::*; (
	input  wire                     MCLK,
	input  wire                     reset,
	input  wire                     host_req,
	output logic                    host_ack,
	input  wire [`MBUS_ADDR_W-1:0]  host_addr,
	input  wire [`MBUS_DATA_W-1:0]  host_wdata,
	input  wire                     host_rnw,
	input  wire [1:0]               host_be,
	bus_cmd_if.producer             cmd
);

	mbus_cmd_t cmd_q;
	logic      take;

	function automatic mbus_region_e region_of(input logic [`MBUS_ADDR_W-1:0] addr);
		if (addr[22:20] == `RAM_PAGE)
			return REGION_RAM;
		else if (addr < `ROM_END_WORD)
			return REGION_ROM;
		else if (addr[22:7] == `BANK_PAGE)
			return REGION_BANK;
		else
			return REGION_OPEN;
	endfunction

	// New host cycle only once both handshakes are back at rest
	assign take = host_req && !host_ack && !cmd.req && !cmd.ack;

	always_ff @(posedge MCLK) begin
		if (take) begin
			cmd_q.addr.flat <= host_addr;
			cmd_q.wdata     <= host_wdata;
			cmd_q.rnw       <= host_rnw;
			cmd_q.be        <= host_be;
			cmd_q.region    <= region_of(host_addr);
		end
	end

	assign cmd.cmd = cmd_q;

	//------------------------------
	// Handshakes
	//------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			cmd.req  <= 1'b0;
			host_ack <= 1'b0;
		end else begin
			if (take) begin
				cmd.req <= 1'b1;
			end else if (cmd.req && cmd.ack) begin
				// Queue has it, release the host
				cmd.req  <= 1'b0;
				host_ack <= 1'b1;
			end
			if (host_ack && !host_req)
				host_ack <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- design/mbus_defines.svh
// Main bus widths and address map
`ifndef MBUS_DEFINES_SVH
`define MBUS_DEFINES_SVH

// Bus widths
`define MBUS_ADDR_W 23
`define MBUS_DATA_W 16
`define ROM_ADDR_W 23

// Storage depths
`define RAM_WORDS_LOG2 15
`define FIFO_DEPTH_LOG2 2

// Address map, all word addresses
// ROM sits below 4 MB
`define ROM_END_WORD 23'h200000
// Work RAM is the top 2 MB, E00000-FFFFFF
`define RAM_PAGE 3'b111
// Bank register page A130xx
`define BANK_PAGE 16'hA130

// Reset values
`define OPEN_BUS_RESET 16'h4E71
`define BANK_SLOTS 8

`endif

//--- design/mbus_pkg.sv
// Main bus command types
`default_nettype none

`include "mbus_defines.svh"

package mbus_pkg;

	// One word address, read flat or as a banked ROM address
	// Bank view: page is byte 23..22, slot byte 21..19, offset byte 18..1
	typedef union packed {
		logic [`MBUS_ADDR_W-1:0] flat;
		struct packed {
			logic [1:0]  page;
			logic [2:0]  slot;
			logic [17:0] offset;
		} bank;
	} mbus_addr_u;

	typedef enum logic [1:0] {
		REGION_RAM,
		REGION_ROM,
		REGION_BANK,
		REGION_OPEN
	} mbus_region_e;

	typedef struct packed {
		mbus_addr_u              addr;
		logic [`MBUS_DATA_W-1:0] wdata;
		logic                    rnw;
		// Bit 1 is the upper byte
		logic [1:0]              be;
		mbus_region_e            region;
	} mbus_cmd_t;

endpackage

`default_nettype wire

//--- design/mbus_sequencer.sv
// Main bus sequencer with work RAM and ROM banking
`default_nettype none

`include "mbus_defines.svh"

module mbus_sequencer import mbus_pkg::*; (
	input  wire                    MCLK,
	input  wire                    reset,
	bus_cmd_if.consumer            cmd,
	output logic                   rd_valid,
	output logic [`MBUS_DATA_W-1:0] rd_data,
	output logic [`ROM_ADDR_W-1:0] rom_addr,
	output logic                   rom_req,
	input  wire                    rom_ack,
	input  wire [`MBUS_DATA_W-1:0] rom_data
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RAM,
		S_ROM_WAIT,
		S_FINISH
	} seq_state_e;

	seq_state_e              state;
	mbus_cmd_t               cur;
	mbus_addr_u              in_addr;
	logic                    take;
	logic                    rom_done;
	logic [`ROM_ADDR_W-1:0]  rom_target;
	logic [`MBUS_DATA_W-1:0] open_bus;
	logic [`MBUS_DATA_W-1:0] resp;
	logic [`MBUS_DATA_W-1:0] ram_q;
	logic [4:0]              bank_reg [`BANK_SLOTS];
	logic                    bank_mode;

	logic [`MBUS_DATA_W-1:0] ram [1 << `RAM_WORDS_LOG2];

	assign in_addr  = cmd.cmd.addr;
	assign take     = (state == S_IDLE) && cmd.req && !cmd.ack;
	assign rom_done = (rom_req == rom_ack);

	// 512 KB windows remapped by the slot register
	always_comb begin
		if (bank_mode)
			rom_target = {bank_reg[in_addr.bank.slot], in_addr.bank.offset};
		else
			rom_target = in_addr.flat;
	end

	//------------------------------
	// Work RAM
	//------------------------------
	always_ff @(posedge MCLK) begin
		if (state == S_RAM) begin
			if (!cur.rnw && cur.be[1])
				ram[cur.addr.flat[`RAM_WORDS_LOG2-1:0]][15:8] <= cur.wdata[15:8];
			if (!cur.rnw && cur.be[0])
				ram[cur.addr.flat[`RAM_WORDS_LOG2-1:0]][7:0] <= cur.wdata[7:0];
			ram_q <= ram[cur.addr.flat[`RAM_WORDS_LOG2-1:0]];
		end
	end

	// Command and response data
	always_ff @(posedge MCLK) begin
		if (take) begin
			cur      <= cmd.cmd;
			rom_addr <= rom_target;
			resp     <= open_bus;
		end
		if (state == S_ROM_WAIT && rom_done)
			resp <= rom_data;
		if (state == S_FINISH)
			rd_data <= (cur.region == REGION_RAM) ? ram_q : resp;
	end

	//------------------------------
	// FSM
	//------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state     <= S_IDLE;
			cmd.ack   <= 1'b0;
			rom_req   <= 1'b0;
			rd_valid  <= 1'b0;
			bank_mode <= 1'b0;
			open_bus  <= `OPEN_BUS_RESET;
			for (int i = 0; i < `BANK_SLOTS; i++)
				bank_reg[i] <= 5'(i);
		end else begin
			rd_valid <= 1'b0;
			if (cmd.ack && !cmd.req)
				cmd.ack <= 1'b0;

			case (state)
				S_IDLE: begin
					if (take) begin
						cmd.ack <= 1'b1;
						case (cmd.cmd.region)
							REGION_RAM:
								state <= S_RAM;
							REGION_ROM: begin
								// Writes to ROM are dropped
								if (cmd.cmd.rnw) begin
									rom_req <= ~rom_req;
									state   <= S_ROM_WAIT;
								end else begin
									state <= S_FINISH;
								end
							end
							REGION_BANK: begin
								// Slot 0 is fixed
								if (!cmd.cmd.rnw && in_addr.flat[2:0] != 3'd0) begin
									bank_reg[in_addr.flat[2:0]] <= cmd.cmd.wdata[4:0];
									bank_mode <= 1'b1;
								end
								state <= S_FINISH;
							end
							default:
								state <= S_FINISH;
						endcase
					end
				end

				S_RAM:
					state <= S_FINISH;

				S_ROM_WAIT: begin
					if (rom_done) begin
						open_bus <= rom_data;
						state    <= S_FINISH;
					end
				end

				S_FINISH: begin
					rd_valid <= cur.rnw;
					if (cur.region == REGION_RAM && cur.rnw)
						open_bus <= ram_q;
					state <= S_IDLE;
				end

				default:
					state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/mbus_top.sv
// Main bus top level
`default_nettype none

`include "mbus_defines.svh"

module mbus_top (
	input  wire                     MCLK,
	input  wire                     reset,

	// Host bus
	input  wire                     host_req,
	output logic                    host_ack,
	input  wire [`MBUS_ADDR_W-1:0]  host_addr,
	input  wire [`MBUS_DATA_W-1:0]  host_wdata,
	input  wire                     host_rnw,
	input  wire [1:0]               host_be,
	output logic                    rd_valid,
	output logic [`MBUS_DATA_W-1:0] rd_data,

	// Cartridge ROM, toggle handshake
	output logic [`ROM_ADDR_W-1:0]  rom_addr,
	output logic                    rom_req,
	input  wire                     rom_ack,
	input  wire [`MBUS_DATA_W-1:0]  rom_data
);

	bus_cmd_if port_cmd ();
	bus_cmd_if seq_cmd ();

	host_bus_port i_host_bus_port (
		.MCLK       (MCLK),
		.reset      (reset),
		.host_req   (host_req),
		.host_ack   (host_ack),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rnw   (host_rnw),
		.host_be    (host_be),
		.cmd        (port_cmd.producer)
	);

	cmd_fifo i_cmd_fifo (
		.MCLK  (MCLK),
		.reset (reset),
		.wr    (port_cmd.consumer),
		.rd    (seq_cmd.producer)
	);

	mbus_sequencer i_mbus_sequencer (
		.MCLK     (MCLK),
		.reset    (reset),
		.cmd      (seq_cmd.consumer),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.rom_addr (rom_addr),
		.rom_req  (rom_req),
		.rom_ack  (rom_ack),
		.rom_data (rom_data)
	);

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/mbus_pkg.sv
design/bus_cmd_if.sv
design/host_bus_port.sv
design/cmd_fifo.sv
design/mbus_sequencer.sv
design/mbus_top.sv
verification/mbus_asserts.sv
verification/mbus_tb.sv

//--- verification/mbus_asserts.sv
// Main bus protocol assertions
`default_nettype none

module mbus_asserts (
	input wire MCLK,
	input wire reset,
	input wire host_req,
	input wire host_ack,
	input wire rd_valid,
	input wire rom_req,
	input wire rom_ack
);

	timeunit 1ns;
	timeprecision 1ps;

	int unsigned assert_errors = 0;

	// Ack only answers a live request
	ack_needs_req: assert property (@(posedge MCLK) disable iff (reset)
		$rose(host_ack) |-> host_req)
	else begin
		$error("host_ack rose without host_req");
		assert_errors++;
	end

	// Read strobe is a single cycle
	rd_valid_pulse: assert property (@(posedge MCLK) disable iff (reset)
		rd_valid |=> !rd_valid)
	else begin
		$error("rd_valid held for more than one cycle");
		assert_errors++;
	end

	// No new toggle while the cartridge still owes an answer
	rom_req_held: assert property (@(posedge MCLK) disable iff (reset)
		(rom_req != rom_ack) |=> $stable(rom_req))
	else begin
		$error("rom_req flipped while a ROM request was outstanding");
		assert_errors++;
	end

endmodule

`default_nettype wire

//--- verification/mbus_tb.sv
// Main bus testbench
`default_nettype none

`include "mbus_defines.svh"

module mbus_tb import mbus_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ACK_TIMEOUT   = 2000;
	localparam int DRAIN_TIMEOUT = 5000;
	// Byte address A130F0, slot 0 of the bank registers
	localparam logic [`MBUS_ADDR_W-1:0] BANK_BASE = 23'h509878;

	logic                    MCLK;
	logic                    reset;
	logic                    host_req;
	logic                    host_ack;
	logic [`MBUS_ADDR_W-1:0] host_addr;
	logic [`MBUS_DATA_W-1:0] host_wdata;
	logic                    host_rnw;
	logic [1:0]              host_be;
	logic                    rd_valid;
	logic [`MBUS_DATA_W-1:0] rd_data;
	logic [`ROM_ADDR_W-1:0]  rom_addr;
	logic                    rom_req;
	logic                    rom_ack;
	logic [`MBUS_DATA_W-1:0] rom_data;

	int    seed = 41;
	int    errors = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    errors_at_start;
	string test_name;
	bit    rom_slow = 1'b0;

	//------------------------------
	// Reference model state
	//------------------------------
	logic [`MBUS_DATA_W-1:0] model_ram [int];
	logic [4:0]              model_slot [`BANK_SLOTS];
	logic                    model_bank_mode;
	logic [`MBUS_DATA_W-1:0] model_open;
	logic [`MBUS_DATA_W-1:0] exp_data_q [$];
	logic [`ROM_ADDR_W-1:0]  exp_rom_q [$];

	mbus_top i_mbus_top (
		.MCLK       (MCLK),
		.reset      (reset),
		.host_req   (host_req),
		.host_ack   (host_ack),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rnw   (host_rnw),
		.host_be    (host_be),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data),
		.rom_addr   (rom_addr),
		.rom_req    (rom_req),
		.rom_ack    (rom_ack),
		.rom_data   (rom_data)
	);

	bind mbus_top mbus_asserts i_mbus_asserts (
		.MCLK     (MCLK),
		.reset    (reset),
		.host_req (host_req),
		.host_ack (host_ack),
		.rd_valid (rd_valid),
		.rom_req  (rom_req),
		.rom_ack  (rom_ack)
	);

	initial begin
		MCLK = 1'b0;
		forever #5 MCLK = ~MCLK;
	end

	function automatic int total_errors();
		return errors + i_mbus_top.i_mbus_asserts.assert_errors;
	endfunction

	task automatic check_word(input string what, input logic [`MBUS_DATA_W-1:0] got,
			input logic [`MBUS_DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_rom_addr(input logic [`ROM_ADDR_W-1:0] got,
			input logic [`ROM_ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: rom_addr got %h expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_level(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("Timeout at %0t ns: %s", $time, why);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = total_errors();
	endtask

	task automatic end_test();
		int n;
		n = total_errors() - errors_at_start;
		tests_run++;
		if (n != 0)
			tests_failed++;
		$display("Test %0d %s: %s (%0d errors)", tests_run, test_name,
			(n == 0) ? "ok" : "failed", n);
	endtask

	// Address map as seen from the byte side
	function automatic mbus_region_e classify(input logic [`MBUS_ADDR_W-1:0] addr);
		logic [23:0] byte_addr;
		byte_addr = {addr, 1'b0};
		if (byte_addr >= 24'hE00000)
			return REGION_RAM;
		if (byte_addr < 24'h400000)
			return REGION_ROM;
		if (byte_addr[23:8] == 16'hA130)
			return REGION_BANK;
		return REGION_OPEN;
	endfunction

	// Somewhere in 600000-7FFFFE, clear of the bank page
	function automatic logic [`MBUS_ADDR_W-1:0] rand_open_addr();
		return 23'h300000 | 23'($random(seed) & 'hFFFFF);
	endfunction

	task automatic model_apply(input mbus_cmd_t c);
		logic [`ROM_ADDR_W-1:0]  rom_word;
		logic [`MBUS_DATA_W-1:0] word;
		int                      idx;
		idx = int'(c.addr.flat[`RAM_WORDS_LOG2-1:0]);
		case (c.region)
			REGION_RAM: begin
				word = model_ram.exists(idx) ? model_ram[idx] : '0;
				if (c.rnw) begin
					exp_data_q.push_back(word);
					model_open = word;
				end else begin
					if (c.be[1])
						word[15:8] = c.wdata[15:8];
					if (c.be[0])
						word[7:0] = c.wdata[7:0];
					model_ram[idx] = word;
				end
			end
			REGION_ROM: begin
				if (c.rnw) begin
					rom_word = c.addr.flat;
					// 512 KB window, slot from byte bits 21..19
					if (model_bank_mode)
						rom_word = {model_slot[c.addr.flat[20:18]], c.addr.flat[17:0]};
					exp_rom_q.push_back(rom_word);
					word = rom_word[15:0] ^ 16'hA5A5;
					exp_data_q.push_back(word);
					model_open = word;
				end
			end
			REGION_BANK: begin
				if (c.rnw) begin
					exp_data_q.push_back(model_open);
				end else if (c.addr.flat[2:0] != 3'd0) begin
					model_slot[c.addr.flat[2:0]] = c.wdata[4:0];
					model_bank_mode = 1'b1;
				end
			end
			default: begin
				if (c.rnw)
					exp_data_q.push_back(model_open);
			end
		endcase
	endtask

	//------------------------------
	// Host side four-phase cycle
	//------------------------------
	task automatic issue_cycle(input logic [`MBUS_ADDR_W-1:0] addr,
			input logic [`MBUS_DATA_W-1:0] wdata, input logic rnw, input logic [1:0] be);
		mbus_cmd_t c;
		int        waited;
		c.addr.flat = addr;
		c.wdata     = wdata;
		c.rnw       = rnw;
		c.be        = be;
		c.region    = classify(addr);
		model_apply(c);
		host_addr  <= addr;
		host_wdata <= wdata;
		host_rnw   <= rnw;
		host_be    <= be;
		host_req   <= 1'b1;
		waited = 0;
		do begin
			@(posedge MCLK);
			waited++;
			if (waited > ACK_TIMEOUT)
				abort_run("host_ack never rose for a pending request");
		end while (!host_ack);
		host_req <= 1'b0;
		waited = 0;
		do begin
			@(posedge MCLK);
			waited++;
			if (waited > ACK_TIMEOUT)
				abort_run("host_ack stayed high after host_req fell");
		end while (host_ack);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_data_q.size() != 0 || exp_rom_q.size() != 0) begin
			@(posedge MCLK);
			waited++;
			if (waited > DRAIN_TIMEOUT)
				abort_run("not every read response arrived");
		end
	endtask

	// Cartridge ROM, answers after a random delay
	initial begin : rom_responder
		int delay;
		bit busy;
		rom_ack  = 1'b0;
		rom_data = '0;
		busy     = 1'b0;
		delay    = 0;
		forever begin
			@(posedge MCLK);
			if (reset) begin
				busy = 1'b0;
			end else begin
				if (!busy && rom_req != rom_ack) begin
					busy = 1'b1;
					if (exp_rom_q.size() == 0) begin
						$display("ROM request at %0t ns with no ROM read expected", $time);
						errors++;
					end else begin
						check_rom_addr(rom_addr, exp_rom_q.pop_front());
					end
					if (rom_slow)
						delay = 8 + ($random(seed) & 7);
					else
						delay = $random(seed) & 15;
				end
				if (busy) begin
					if (delay == 0) begin
						rom_data <= rom_addr[15:0] ^ 16'hA5A5;
						rom_ack  <= rom_req;
						busy = 1'b0;
					end else begin
						delay = delay - 1;
					end
				end
			end
		end
	end

	initial begin : read_monitor
		forever begin
			@(posedge MCLK);
			if (!reset && rd_valid) begin
				if (exp_data_q.size() == 0) begin
					$display("Read response at %0t ns with no read pending", $time);
					errors++;
				end else begin
					check_word("rd_data", rd_data, exp_data_q.pop_front());
				end
			end
		end
	end

	initial begin : main
		int                      i;
		int                      k;
		logic [`MBUS_ADDR_W-1:0] a;
		logic [`MBUS_ADDR_W-1:0] ram_pool [16];
		reset      = 1'b1;
		host_req   = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		host_rnw   = 1'b1;
		host_be    = 2'b00;
		model_bank_mode = 1'b0;
		model_open      = `OPEN_BUS_RESET;
		for (i = 0; i < `BANK_SLOTS; i++)
			model_slot[i] = 5'(i);
		// Distinct low bits so no two entries share a RAM word
		for (i = 0; i < 16; i++)
			ram_pool[i] = 23'h780000 + 23'(i * 'h101);
		repeat (4) @(posedge MCLK);
		reset <= 1'b0;
		@(posedge MCLK);

		start_test("reset and unbanked ROM");
		check_level("host_ack", host_ack, 1'b0);
		check_level("rd_valid", rd_valid, 1'b0);
		check_level("rom_req", rom_req, 1'b0);
		issue_cycle(rand_open_addr(), '0, 1'b1, 2'b11);
		issue_cycle(23'($random(seed)) & 23'h1FFFFF, '0, 1'b1, 2'b11);
		wait_drain();
		end_test();

		start_test("RAM byte lanes");
		for (i = 0; i < 16; i++)
			issue_cycle(ram_pool[i], 16'($random(seed)), 1'b0, 2'b11);
		for (i = 0; i < 60; i++) begin
			k = $random(seed) & 15;
			if ($random(seed) & 1)
				issue_cycle(ram_pool[k], 16'($random(seed)), 1'b0, 2'($random(seed)));
			else
				issue_cycle(ram_pool[k], '0, 1'b1, 2'b11);
		end
		for (i = 0; i < 16; i++)
			issue_cycle(ram_pool[i], '0, 1'b1, 2'b11);
		wait_drain();
		end_test();

		start_test("bank windows");
		for (i = 0; i < `BANK_SLOTS; i++)
			issue_cycle(BANK_BASE + 23'(i), 16'($random(seed)), 1'b0, 2'b11);
		for (i = 0; i < `BANK_SLOTS; i++) begin
			a = {2'b00, 3'(i), 18'($random(seed))};
			issue_cycle(a, '0, 1'b1, 2'b11);
		end
		wait_drain();
		end_test();

		start_test("open bus");
		issue_cycle(rand_open_addr(), '0, 1'b1, 2'b11);
		issue_cycle(rand_open_addr(), 16'($random(seed)), 1'b0, 2'b11);
		issue_cycle(rand_open_addr(), '0, 1'b1, 2'b11);
		issue_cycle(23'h509800 | 23'($random(seed) & 'h7F), '0, 1'b1, 2'b11);
		issue_cycle(ram_pool[3], 16'($random(seed)), 1'b0, 2'b11);
		issue_cycle(rand_open_addr(), '0, 1'b1, 2'b11);
		issue_cycle(23'($random(seed)) & 23'h1FFFFF, 16'($random(seed)), 1'b0, 2'b11);
		issue_cycle(rand_open_addr(), '0, 1'b1, 2'b11);
		issue_cycle(ram_pool[3], '0, 1'b1, 2'b11);
		issue_cycle(23'h509800 | 23'($random(seed) & 'h7F), '0, 1'b1, 2'b11);
		issue_cycle(rand_open_addr(), '0, 1'b1, 2'b11);
		wait_drain();
		end_test();

		start_test("burst with slow ROM");
		rom_slow = 1'b1;
		for (i = 0; i < 48; i++) begin
			k = $random(seed) & 7;
			case (k)
				0, 1:
					issue_cycle(23'($random(seed)) & 23'h1FFFFF, '0, 1'b1, 2'b11);
				2:
					issue_cycle(ram_pool[$random(seed) & 15], 16'($random(seed)), 1'b0,
						2'($random(seed)));
				3:
					issue_cycle(ram_pool[$random(seed) & 15], '0, 1'b1, 2'b11);
				4:
					issue_cycle(rand_open_addr(), '0, 1'b1, 2'b11);
				5:
					issue_cycle(23'h509800 | 23'($random(seed) & 'h7F), '0, 1'b1, 2'b11);
				6:
					issue_cycle(BANK_BASE + 23'($random(seed) & 7), 16'($random(seed)),
						1'b0, 2'b11);
				default:
					issue_cycle(rand_open_addr(), 16'($random(seed)), 1'b0, 2'b11);
			endcase
		end
		wait_drain();
		rom_slow = 1'b0;
		end_test();

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			total_errors());
		if (total_errors() == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
